// ==== design/npu_pkg.sv ====
`default_nettype none

package npu_pkg;

    typedef logic [31:0] npu_word_t;
    typedef logic [31:0] npu_addr_t;

    // Operands entering row r (a) and column r (b) of the array
    typedef struct packed {
        npu_word_t a;
        npu_word_t b;
    } npu_lane_t;

    typedef struct packed {
        npu_addr_t addr;
        npu_word_t data;
    } npu_xfer_t;

    // Memory layout is A, then B, then C, each mat_dim squared words long
    function automatic npu_addr_t a_base_word(input int mat_dim);
        return '0;
    endfunction

    function automatic npu_addr_t b_base_word(input int mat_dim);
        return npu_addr_t'(mat_dim * mat_dim);
    endfunction

    function automatic npu_addr_t c_base_word(input int mat_dim);
        return npu_addr_t'(2 * mat_dim * mat_dim);
    endfunction

    function automatic npu_addr_t byte_addr(input npu_addr_t word_idx);
        return word_idx << 2;
    endfunction

endpackage

`default_nettype wire

// ==== design/npu_mac_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_mac_cell (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  npu_pkg::npu_word_t a_in,
    input  npu_pkg::npu_word_t b_in,
    output npu_pkg::npu_word_t a_out,
    output npu_pkg::npu_word_t b_out,
    output npu_pkg::npu_word_t acc
);

    // Operands move one cell right (a) and one cell down (b) per cycle,
    // while the partial sum of this output element stays put
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            // Product and sum both truncate to 32 bits, so C wraps mod 2^32
            acc   <= acc + a_in * b_in;
        end
    end

endmodule

`default_nettype wire

// ==== design/npu_systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_systolic_array #(
    parameter int mat_dim = 3
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      clear,
    input  npu_pkg::npu_lane_t [mat_dim-1:0]          lanes,
    output npu_pkg::npu_word_t [mat_dim*mat_dim-1:0]  result
);

    import npu_pkg::*;

    // a_link[r][c] feeds cell (r,c) from the left, b_link[r][c] from above.
    // The extra column and row hold what leaves the far edge of the grid
    npu_word_t a_link [mat_dim][mat_dim+1];
    npu_word_t b_link [mat_dim+1][mat_dim];

    genvar r;
    genvar c;

    for (r = 0; r < mat_dim; r++) begin : g_edge
        assign a_link[r][0] = lanes[r].a;
        assign b_link[0][r] = lanes[r].b;
    end

    for (r = 0; r < mat_dim; r++) begin : g_row
        for (c = 0; c < mat_dim; c++) begin : g_col
            npu_mac_cell u_cell (
                .clk   (clk),
                .rst   (rst),
                .clear (clear),
                .a_in  (a_link[r][c]),
                .b_in  (b_link[r][c]),
                .a_out (a_link[r][c+1]),
                .b_out (b_link[r+1][c]),
                .acc   (result[r*mat_dim+c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== design/npu_operand_feeder.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_operand_feeder #(
    parameter int mat_dim = 3
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             en,
    output npu_pkg::npu_addr_t [mat_dim-1:0] rd_a_idx,
    output npu_pkg::npu_addr_t [mat_dim-1:0] rd_b_idx,
    input  npu_pkg::npu_word_t [mat_dim-1:0] rd_a_word,
    input  npu_pkg::npu_word_t [mat_dim-1:0] rd_b_word,
    output npu_pkg::npu_lane_t [mat_dim-1:0] lanes,
    output logic                             clear,
    output logic                             capture
);

    import npu_pkg::*;

    // The last cell finishes at step 3*mat_dim-3, capture waits two more steps
    localparam int last_step = 3 * mat_dim - 1;
    localparam int step_w    = $clog2(3 * mat_dim);

    logic              en_q;
    logic              start;
    logic              busy;
    logic [step_w-1:0] step;

    assign start   = en && !en_q;
    assign clear   = start;
    assign capture = busy && en && (step == step_w'(last_step));

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= 1'b0;
            busy <= 1'b0;
            step <= '0;
        end else begin
            en_q <= en;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (!en || capture) begin
                // Either the run finished or the CPU dropped en and aborted it
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    // Lane r is skewed by r steps, so it carries k = step - r
    always_comb begin
        int  k;
        int  kk;
        logic live;
        for (int r = 0; r < mat_dim; r++) begin
            k    = int'(step) - r;
            live = busy && (k >= 0) && (k < mat_dim);
            // Keep the read index in range while the lane is idle
            kk   = live ? k : 0;
            rd_a_idx[r] = a_base_word(mat_dim) + npu_addr_t'(r * mat_dim + kk);
            rd_b_idx[r] = b_base_word(mat_dim) + npu_addr_t'(kk * mat_dim + r);
            lanes[r].a  = live ? rd_a_word[r] : '0;
            lanes[r].b  = live ? rd_b_word[r] : '0;
        end
    end

    // A capture belongs to a run whose start was seen 3*mat_dim cycles ago
    a_capture_in_run: assert property (
        @(posedge clk) disable iff (rst)
        capture |-> en && $past(start, 3 * mat_dim)
    );

endmodule

`default_nettype wire

// ==== design/npu_scratch_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_scratch_mem #(
    parameter int mat_dim = 3
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     get_wr,
    input  npu_pkg::npu_addr_t                       get_addr,
    input  npu_pkg::npu_word_t                       get_data,
    input  npu_pkg::npu_addr_t [mat_dim-1:0]         rd_a_idx,
    input  npu_pkg::npu_addr_t [mat_dim-1:0]         rd_b_idx,
    output npu_pkg::npu_word_t [mat_dim-1:0]         rd_a_word,
    output npu_pkg::npu_word_t [mat_dim-1:0]         rd_b_word,
    input  logic                                     capture,
    input  npu_pkg::npu_word_t [mat_dim*mat_dim-1:0] result,
    input  npu_pkg::npu_addr_t                       c_word_idx,
    output npu_pkg::npu_word_t                       c_word
);

    import npu_pkg::*;

    localparam int mat_words = mat_dim * mat_dim;
    localparam int mem_words = 3 * mat_words;

    npu_word_t mem [mem_words];
    npu_addr_t c_off;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (get_wr) begin
                mem[get_addr] <= get_data;
            end
            // Written after the CPU port so the result wins on the same word
            if (capture) begin
                for (int i = 0; i < mat_words; i++) begin
                    mem[c_base_word(mat_dim) + npu_addr_t'(i)] <= result[i];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < mat_dim; r++) begin
            rd_a_word[r] = mem[rd_a_idx[r]];
            rd_b_word[r] = mem[rd_b_idx[r]];
        end
    end

    // A C read in the capture cycle sees the result being written,
    // which lets the drain start its burst in that same cycle
    assign c_off  = c_word_idx - c_base_word(mat_dim);
    assign c_word = capture ? result[c_off] : mem[c_word_idx];

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        get_wr |-> get_addr < npu_addr_t'(mem_words)
    );

endmodule

`default_nettype wire

// ==== design/npu_result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_result_drain #(
    parameter int mat_dim = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               capture,
    output npu_pkg::npu_addr_t c_word_idx,
    input  npu_pkg::npu_word_t c_word,
    output logic               pass_we,
    output logic               ack,
    output npu_pkg::npu_xfer_t xfer
);

    import npu_pkg::*;

    localparam int mat_words = mat_dim * mat_dim;
    localparam int cnt_w     = $clog2(mat_words + 1);

    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic             last;
    logic             fetch;

    // cnt is the next C word to send and sits at zero while idle
    assign c_word_idx = c_base_word(mat_dim) + npu_addr_t'(cnt);
    assign last       = (cnt == cnt_w'(mat_words));
    assign fetch      = busy ? !last : capture;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            pass_we <= 1'b0;
            ack     <= 1'b0;
            xfer    <= '0;
        end else begin
            pass_we <= fetch;
            ack     <= busy && last;
            if (fetch) begin
                busy      <= 1'b1;
                cnt       <= cnt + 1'b1;
                xfer.addr <= byte_addr(c_word_idx);
                xfer.data <= c_word;
            end else begin
                // Bus returns to zero between bursts
                busy <= 1'b0;
                cnt  <= '0;
                xfer <= '0;
            end
        end
    end

    // ack closes a burst of exactly mat_words transfers and never overlaps one
    a_ack_closes_burst: assert property (
        @(posedge clk) disable iff (rst)
        ack |-> !pass_we && $past(pass_we) && $past(pass_we, mat_words)
            && !$past(pass_we, mat_words + 1)
    );

    // The feeder needs at least 3*mat_dim cycles per run, so a second
    // capture cannot land inside a burst unless the run timing broke
    a_no_capture_in_burst: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> !capture
    );

endmodule

`default_nettype wire

// ==== design/npu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu #(
    parameter int mat_dim = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               get_wr,
    input  npu_pkg::npu_addr_t get_addr,
    input  npu_pkg::npu_word_t get_data,
    output logic               pass_we,
    output logic               ack,
    output npu_pkg::npu_addr_t modified_addr,
    output npu_pkg::npu_word_t modified_data
);

    import npu_pkg::*;

    npu_addr_t [mat_dim-1:0]         rd_a_idx;
    npu_addr_t [mat_dim-1:0]         rd_b_idx;
    npu_word_t [mat_dim-1:0]         rd_a_word;
    npu_word_t [mat_dim-1:0]         rd_b_word;
    npu_lane_t [mat_dim-1:0]         lanes;
    npu_word_t [mat_dim*mat_dim-1:0] result;
    logic                            clear;
    logic                            capture;
    npu_addr_t                       c_word_idx;
    npu_word_t                       c_word;
    npu_xfer_t                       xfer;

    npu_operand_feeder #(
        .mat_dim (mat_dim)
    ) u_feeder (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .rd_a_word (rd_a_word),
        .rd_b_word (rd_b_word),
        .lanes     (lanes),
        .clear     (clear),
        .capture   (capture)
    );

    npu_scratch_mem #(
        .mat_dim (mat_dim)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .get_wr     (get_wr),
        .get_addr   (get_addr),
        .get_data   (get_data),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_word  (rd_a_word),
        .rd_b_word  (rd_b_word),
        .capture    (capture),
        .result     (result),
        .c_word_idx (c_word_idx),
        .c_word     (c_word)
    );

    npu_systolic_array #(
        .mat_dim (mat_dim)
    ) u_array (
        .clk    (clk),
        .rst    (rst),
        .clear  (clear),
        .lanes  (lanes),
        .result (result)
    );

    npu_result_drain #(
        .mat_dim (mat_dim)
    ) u_drain (
        .clk        (clk),
        .rst        (rst),
        .capture    (capture),
        .c_word_idx (c_word_idx),
        .c_word     (c_word),
        .pass_we    (pass_we),
        .ack        (ack),
        .xfer       (xfer)
    );

    // CPU sees the transfer as separate address and data buses
    assign modified_addr = xfer.addr;
    assign modified_data = xfer.data;

endmodule

`default_nettype wire

// ==== test/npu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module npu_tb;

    import npu_pkg::*;

    localparam int mat_dim     = 3;
    localparam int mat_words   = mat_dim * mat_dim;
    localparam int c_base_byte = 2 * mat_words * 4;
    localparam int num_random  = 20;
    localparam int num_wrap    = 4;
    // One zero run, the random and wrap runs, and two partial-rewrite runs
    localparam int num_runs    = 1 + num_random + num_wrap + 2;
    localparam int ack_limit   = 200;
    localparam int hold_cycles = 12;

    logic      clk;
    logic      rst;
    logic      en;
    logic      get_wr;
    npu_addr_t get_addr;
    npu_word_t get_data;
    logic      pass_we;
    logic      ack;
    npu_addr_t modified_addr;
    npu_word_t modified_data;

    // Testbench copies of the operands and the expected product
    npu_word_t a_m [mat_words];
    npu_word_t b_m [mat_words];
    npu_word_t c_m [mat_words];

    npu_xfer_t got_q [$];
    int        we_cyc_q [$];
    int        ack_cyc_q [$];
    int        cyc;

    string cur_test;
    int    errors;
    int    test_errs;
    int    tests_ok;
    int    tests_bad;

    npu #(
        .mat_dim (mat_dim)
    ) npu_i (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .get_wr        (get_wr),
        .get_addr      (get_addr),
        .get_data      (get_data),
        .pass_we       (pass_we),
        .ack           (ack),
        .modified_addr (modified_addr),
        .modified_data (modified_data)
    );

    always #5 clk = ~clk;

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!rst) begin
            if (pass_we) begin
                got_q.push_back({modified_addr, modified_data});
                we_cyc_q.push_back(cyc);
            end
            if (ack) begin
                ack_cyc_q.push_back(cyc);
            end
        end
    end

    initial begin
        repeat (200 * num_runs) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the tests completing",
                 200 * num_runs);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_xfer(input npu_xfer_t exp, input npu_xfer_t act);
        if (act !== exp) begin
            $display("[FAIL] %s xfer: expected addr=%h data=%h, actual addr=%h data=%h",
                     cur_test, exp.addr, exp.data, act.addr, act.data);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        if (errors == test_errs) begin
            tests_ok++;
            $display("%-12s ok", cur_test);
        end else begin
            tests_bad++;
            $display("%-12s %0d mismatches", cur_test, errors - test_errs);
        end
    endtask

    // Row-major product, every step truncated to 32 bits
    function automatic void compute_model();
        npu_word_t acc;
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                acc = '0;
                for (int k = 0; k < mat_dim; k++) begin
                    acc = acc + a_m[r*mat_dim+k] * b_m[k*mat_dim+c];
                end
                c_m[r*mat_dim+c] = acc;
            end
        end
    endfunction

    function automatic npu_word_t small_word();
        return npu_word_t'($urandom_range(0, 200)) - 32'd100;
    endfunction

    task automatic write_operands(input bit with_b);
        for (int i = 0; i < mat_words; i++) begin
            @(posedge clk);
            get_wr   <= 1'b1;
            get_addr <= npu_addr_t'(i);
            get_data <= a_m[i];
        end
        if (with_b) begin
            for (int i = 0; i < mat_words; i++) begin
                @(posedge clk);
                get_wr   <= 1'b1;
                get_addr <= npu_addr_t'(mat_words + i);
                get_data <= b_m[i];
            end
        end
        @(posedge clk);
        get_wr <= 1'b0;
    endtask

    task automatic run_and_check();
        int        waited;
        logic      got_ack;
        logic      consecutive;
        logic      ack_follows;
        npu_xfer_t exp_x;
        compute_model();
        got_q.delete();
        we_cyc_q.delete();
        ack_cyc_q.delete();
        @(posedge clk);
        en <= 1'b1;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < ack_limit) begin
            @(negedge clk);
            waited++;
            got_ack = ack;
        end
        if (!got_ack) begin
            $display("%s: no ack arrived within %0d cycles of raising en", cur_test, ack_limit);
            errors++;
        end
        // Keep en high to catch a second burst or a repeated ack
        repeat (hold_cycles) @(negedge clk);
        @(posedge clk);
        en <= 1'b0;
        @(posedge clk);
        if (got_q.size() != mat_words) begin
            $display("[FAIL] %s transfer count: expected %0d, actual %0d",
                     cur_test, mat_words, got_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < mat_words; i++) begin
            exp_x.addr = npu_addr_t'(c_base_byte + 4 * i);
            exp_x.data = c_m[i];
            check_xfer(exp_x, got_q[i]);
        end
        consecutive = 1'b1;
        for (int i = 1; i < we_cyc_q.size(); i++) begin
            if (we_cyc_q[i] != we_cyc_q[i-1] + 1) begin
                consecutive = 1'b0;
            end
        end
        check_flag("burst consecutive", 1'b1, consecutive);
        check_flag("single ack", 1'b1, ack_cyc_q.size() == 1);
        ack_follows = (ack_cyc_q.size() > 0) && (we_cyc_q.size() > 0) &&
                      (ack_cyc_q[0] == we_cyc_q[we_cyc_q.size()-1] + 1);
        check_flag("ack after last", 1'b1, ack_follows);
    endtask

    initial begin
        void'($urandom(32'h84d8));
        clk       = 1'b0;
        rst       = 1'b1;
        en        = 1'b0;
        get_wr    = 1'b0;
        get_addr  = '0;
        get_data  = '0;
        cyc       = 0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        begin_test("idle");
        repeat (20) begin
            @(negedge clk);
            check_flag("pass_we", 1'b0, pass_we);
            check_flag("ack", 1'b0, ack);
            check_xfer('0, {modified_addr, modified_data});
        end
        end_test();

        // Memory is still all zero from reset
        begin_test("zero_run");
        for (int i = 0; i < mat_words; i++) begin
            a_m[i] = '0;
            b_m[i] = '0;
        end
        run_and_check();
        end_test();

        for (int n = 0; n < num_random; n++) begin
            begin_test($sformatf("random_%02d", n));
            for (int i = 0; i < mat_words; i++) begin
                a_m[i] = small_word();
                b_m[i] = small_word();
            end
            write_operands(1'b1);
            run_and_check();
            end_test();
        end

        for (int n = 0; n < num_wrap; n++) begin
            begin_test($sformatf("wrap_%02d", n));
            for (int i = 0; i < mat_words; i++) begin
                a_m[i] = $urandom;
                b_m[i] = $urandom;
            end
            write_operands(1'b1);
            run_and_check();
            end_test();
        end

        begin_test("rewrite_base");
        for (int i = 0; i < mat_words; i++) begin
            a_m[i] = small_word();
            b_m[i] = small_word();
        end
        write_operands(1'b1);
        run_and_check();
        end_test();

        // Only A changes, B must come from what the memory kept
        begin_test("rewrite_a");
        for (int i = 0; i < mat_words; i++) begin
            a_m[i] = small_word();
        end
        write_operands(1'b0);
        run_and_check();
        end_test();

        $display("Tests: %0d ok, %0d with mismatches, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/npu_pkg.sv
design/npu_mac_cell.sv
design/npu_systolic_array.sv
design/npu_operand_feeder.sv
design/npu_scratch_mem.sv
design/npu_result_drain.sv
design/npu.sv
test/npu_tb.sv
